// ==== hdl/mure_pkg.sv ====
// ------------------
// trace ingress package
// widths, type encodings and the commit and uop records
// ------------------
`default_nettype none

package mure_pkg;

    // address and trap value width
    localparam int XLEN        = 32;
    localparam int PRIV_LEN    = 2;
    localparam int CAUSE_LEN   = 5;
    // halfword count of one block
    localparam int IRETIRE_LEN = 8;

    // block type as seen by the trace encoder
    typedef enum logic [2:0] {
        ITYPE_STD   = 3'd0,
        ITYPE_EXC   = 3'd1,
        ITYPE_INT   = 3'd2,
        ITYPE_ERET  = 3'd3,
        ITYPE_BR_NT = 3'd4,
        ITYPE_BR_T  = 3'd5
    } itype_e;

    // opcode class reported by the core
    typedef enum logic [1:0] {
        OP_OTHER  = 2'd0,
        OP_BRANCH = 2'd1,
        OP_ERET   = 2'd2
    } op_e;

    // one commit port of the core
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        op_e             op;
        logic            is_compressed;
        logic            branch_taken;
    } commit_instr_t;

    // classified instruction, one FIFO entry
    typedef struct packed {
        logic                 valid;
        logic [XLEN-1:0]      pc;
        itype_e               itype;
        logic                 compressed;
        logic [PRIV_LEN-1:0]  priv;
        // only filled on port 0 for traps
        logic [CAUSE_LEN-1:0] cause;
        logic [XLEN-1:0]      tval;
    } uop_entry_t;

endpackage

`default_nettype wire

// ==== hdl/uop_if.sv ====
// ------------------
// serialized uop link
// ------------------
`timescale 1ns/1ps
`default_nettype none

interface uop_if import mure_pkg::*; ();

    logic                 valid;
    logic [XLEN-1:0]      pc;
    itype_e               itype;
    logic                 compressed;
    logic [PRIV_LEN-1:0]  priv;
    logic [CAUSE_LEN-1:0] cause;
    logic [XLEN-1:0]      tval;

    // serializer side
    modport src (
        output valid, pc, itype, compressed, priv, cause, tval
    );

    // block builder side, never stalls
    modport snk (
        input valid, pc, itype, compressed, priv, cause, tval
    );

endinterface

`default_nettype wire

// ==== hdl/itype_detector.sv ====
// ------------------
// instruction type detector
// classifies one commit port for the block builder
// ------------------
`timescale 1ns/1ps
`default_nettype none

module itype_detector import mure_pkg::*; (
    input  op_e    op_i,
    input  logic   branch_taken_i,
    input  logic   exception_i,
    input  logic   interrupt_i,
    output itype_e itype_o
);

    // traps win over the opcode
    always_comb begin
        if (exception_i) begin
            itype_o = ITYPE_EXC;
        end else if (interrupt_i) begin
            itype_o = ITYPE_INT;
        end else begin
            case (op_i)
                OP_ERET: begin
                    itype_o = ITYPE_ERET;
                end
                OP_BRANCH: begin
                    itype_o = branch_taken_i ? ITYPE_BR_T : ITYPE_BR_NT;
                end
                default: begin
                    itype_o = ITYPE_STD;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/uop_fifo.sv ====
// ------------------
// uop FIFO
// circular buffer of classified commit entries
// ------------------
`timescale 1ns/1ps
`default_nettype none

module uop_fifo import mure_pkg::*; #(
    parameter int DEPTH = 8
) (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  uop_entry_t data_i,
    input  logic       push_i,
    input  logic       pop_i,
    output uop_entry_t data_o,
    output logic       full_o,
    output logic       empty_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    uop_entry_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    // illegal requests are dropped here
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    assign full_o  = count_q == CNT_W'(DEPTH);
    assign empty_o = count_q == '0;
    assign data_o  = mem[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                // wrap also for depths that are not a power of two
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: count_q <= count_q + 1'b1;
                2'b01: count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= data_i;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/retire_serializer.sv ====
// ------------------
// retire serializer
// walks the FIFO heads in port order, one per cycle
// ------------------
`timescale 1ns/1ps
`default_nettype none

module retire_serializer import mure_pkg::*; #(
    parameter int NRET = 2
) (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  uop_entry_t head_i [NRET-1:0],
    input  logic       empty_i,
    output logic       pop_o,
    uop_if.src         uop
);

    localparam int IDX_W = (NRET > 1) ? $clog2(NRET) : 1;

    logic [IDX_W-1:0] idx_q;
    uop_entry_t       sel;
    logic             active;
    logic             last;
    logic             trap0;

    // all FIFOs hold the same number of entries
    assign active = !empty_i;
    assign sel    = head_i[idx_q];
    assign last   = idx_q == IDX_W'(NRET - 1);

    // a trap on port 0 drops the rest of its group
    assign trap0 = (idx_q == '0) && head_i[0].valid &&
                   (head_i[0].itype == ITYPE_EXC || head_i[0].itype == ITYPE_INT);

    assign pop_o = active && (last || trap0);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            idx_q <= '0;
        end else if (pop_o) begin
            idx_q <= '0;
        end else if (active) begin
            idx_q <= idx_q + 1'b1;
        end
    end

    // invalid ports still use up their slot
    assign uop.valid      = active && sel.valid;
    assign uop.pc         = sel.pc;
    assign uop.itype      = sel.itype;
    assign uop.compressed = sel.compressed;
    assign uop.priv       = sel.priv;
    assign uop.cause      = sel.cause;
    assign uop.tval       = sel.tval;

endmodule

`default_nettype wire

// ==== hdl/block_builder.sv ====
// ------------------
// block builder
// accumulates uops into trace blocks for the encoder
// ------------------
`timescale 1ns/1ps
`default_nettype none

module block_builder import mure_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    uop_if.snk                     uop,
    output logic                   valid_o,
    output logic [IRETIRE_LEN-1:0] iretire_o,
    output logic                   ilastsize_o,
    output itype_e                 itype_o,
    output logic [CAUSE_LEN-1:0]   cause_o,
    output logic [XLEN-1:0]        tval_o,
    output logic [PRIV_LEN-1:0]    priv_o,
    output logic [XLEN-1:0]        iaddr_o
);

    logic [IRETIRE_LEN-1:0] count_q;
    logic [IRETIRE_LEN-1:0] size_hw;
    logic [XLEN-1:0]        start_q;
    logic                   open_q;
    // last counted instruction was 32 bit
    logic                   last_q;
    logic                   is_trap;
    logic                   closes;

    // halfwords of the incoming instruction
    assign size_hw = uop.compressed ? IRETIRE_LEN'(1) : IRETIRE_LEN'(2);
    assign is_trap = uop.itype == ITYPE_EXC || uop.itype == ITYPE_INT;
    assign closes  = uop.itype != ITYPE_STD;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_o <= 1'b0;
            count_q <= '0;
            open_q  <= 1'b0;
        end else begin
            valid_o <= uop.valid && closes;
            if (uop.valid) begin
                if (closes) begin
                    // next block starts empty
                    count_q <= '0;
                    open_q  <= 1'b0;
                end else begin
                    count_q <= count_q + size_hw;
                    open_q  <= 1'b1;
                end
            end
        end
    end

    // start address and size of the latest plain instruction
    always_ff @(posedge clk_i) begin
        if (uop.valid && !closes) begin
            if (!open_q) begin
                start_q <= uop.pc;
            end
            last_q <= !uop.compressed;
        end
    end

    // finished block record
    always_ff @(posedge clk_i) begin
        if (uop.valid && closes) begin
            itype_o <= uop.itype;
            priv_o  <= uop.priv;
            cause_o <= uop.cause;
            tval_o  <= uop.tval;
            // with nothing pending the closing entry gives the address
            iaddr_o <= open_q ? start_q : uop.pc;
            if (is_trap) begin
                // trapping instruction itself is not retired
                iretire_o   <= count_q;
                ilastsize_o <= open_q && last_q;
            end else begin
                iretire_o   <= count_q + size_hw;
                ilastsize_o <= !uop.compressed;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/multiple_retirement.sv ====
// ------------------
// multiple retirement trace ingress
// commit ports to FIFOs to serializer to block builder
// ------------------
`timescale 1ns/1ps
`default_nettype none

module multiple_retirement import mure_pkg::*; #(
    parameter int NRET       = 2,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  commit_instr_t          commit_instr_i [NRET-1:0],
    input  logic                   exception_valid_i,
    input  logic [CAUSE_LEN-1:0]   exception_cause_i,
    input  logic [XLEN-1:0]        exception_tval_i,
    input  logic                   interrupt_i,
    input  logic [PRIV_LEN-1:0]    priv_lvl_i,
    output logic                   valid_o,
    output logic [IRETIRE_LEN-1:0] iretire_o,
    output logic                   ilastsize_o,
    output itype_e                 itype_o,
    output logic [CAUSE_LEN-1:0]   cause_o,
    output logic [XLEN-1:0]        tval_o,
    output logic [PRIV_LEN-1:0]    priv_o,
    output logic [XLEN-1:0]        iaddr_o
);

    itype_e     itype    [NRET];
    uop_entry_t entry_in [NRET-1:0];
    uop_entry_t head     [NRET-1:0];
    logic       full     [NRET];
    logic       empty    [NRET];
    logic       any_valid;
    logic       push;
    logic       pop;

    uop_if uop_bus ();

    for (genvar i = 0; i < NRET; i++) begin : g_port
        // traps only reach port 0
        itype_detector i_itype_detector (
            .op_i          (commit_instr_i[i].op),
            .branch_taken_i(commit_instr_i[i].branch_taken),
            .exception_i   ((i == 0) ? exception_valid_i : 1'b0),
            .interrupt_i   ((i == 0) ? interrupt_i : 1'b0),
            .itype_o       (itype[i])
        );

        uop_fifo #(
            .DEPTH(FIFO_DEPTH)
        ) i_uop_fifo (
            .clk_i  (clk_i),
            .rst_ni (rst_ni),
            .data_i (entry_in[i]),
            .push_i (push),
            .pop_i  (pop),
            .data_o (head[i]),
            .full_o (full[i]),
            .empty_o(empty[i])
        );
    end

    always_comb begin
        any_valid = 1'b0;
        for (int i = 0; i < NRET; i++) begin
            any_valid             = any_valid | commit_instr_i[i].valid;
            entry_in[i].valid      = commit_instr_i[i].valid;
            entry_in[i].pc         = commit_instr_i[i].pc;
            entry_in[i].itype      = itype[i];
            entry_in[i].compressed = commit_instr_i[i].is_compressed;
            entry_in[i].priv       = priv_lvl_i;
            entry_in[i].cause      = '0;
            entry_in[i].tval       = '0;
        end
        // trap info rides on port 0
        if (exception_valid_i || interrupt_i) begin
            entry_in[0].cause = exception_cause_i;
            entry_in[0].tval  = exception_tval_i;
        end
    end

    // all FIFOs move together, a full cycle is lost
    assign push = any_valid && !full[0];

    retire_serializer #(
        .NRET(NRET)
    ) i_retire_serializer (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .head_i (head),
        .empty_i(empty[0]),
        .pop_o  (pop),
        .uop    (uop_bus.src)
    );

    block_builder i_block_builder (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .uop        (uop_bus.snk),
        .valid_o    (valid_o),
        .iretire_o  (iretire_o),
        .ilastsize_o(ilastsize_o),
        .itype_o    (itype_o),
        .cause_o    (cause_o),
        .tval_o     (tval_o),
        .priv_o     (priv_o),
        .iaddr_o    (iaddr_o)
    );

endmodule

`default_nettype wire

// ==== test/multiple_retirement_sva.sv ====
// --------------------
// trace ingress assertions
// FIFO push/pop legality and block strobe timing
// --------------------
`timescale 1ns/1ps
`default_nettype none

module multiple_retirement_sva import mure_pkg::*; (
    input wire logic       clk_i,
    input wire logic       rst_ni,
    input wire logic       push_i,
    input wire logic       pop_i,
    input wire logic       full_i,
    input wire logic       empty_i,
    input wire logic       valid_i,
    input wire logic       uop_valid_i,
    input wire logic [2:0] uop_itype_i
);

    assert property (@(posedge clk_i) disable iff (!rst_ni) !(push_i && full_i))
        else $error("push into a full FIFO");

    assert property (@(posedge clk_i) disable iff (!rst_ni) !(pop_i && empty_i))
        else $error("pop from an empty FIFO");

    // each strobe belongs to one closing uop, back-to-back blocks give back-to-back strobes
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_i |-> $past(uop_valid_i && uop_itype_i != ITYPE_STD))
        else $error("valid_o without a closing uop in the cycle before");

endmodule

bind uop_fifo multiple_retirement_sva fifo_sva_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .push_i     (push_i),
    .pop_i      (pop_i),
    .full_i     (full_o),
    .empty_i    (empty_o),
    .valid_i    (1'b0),
    .uop_valid_i(1'b0),
    .uop_itype_i(3'd0)
);

bind multiple_retirement multiple_retirement_sva top_sva_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .push_i     (1'b0),
    .pop_i      (1'b0),
    .full_i     (1'b0),
    .empty_i    (1'b1),
    .valid_i    (valid_o),
    .uop_valid_i(uop_bus.valid),
    .uop_itype_i(uop_bus.itype)
);

`default_nettype wire

// ==== test/multiple_retirement_tb.sv ====
// --------------------
// trace ingress testbench
// commit groups from a table, blocks checked against a model
// --------------------
`timescale 1ns/1ps
`default_nettype none

module multiple_retirement_tb import mure_pkg::*; ();

    localparam int NRET    = 2;
    localparam int NROWS   = 11;
    localparam int TIMEOUT = 200;

    typedef struct packed {
        logic [1:0]           v;
        op_e                  op0;
        op_e                  op1;
        logic [1:0]           tk;
        logic                 exc;
        logic                 intr;
        logic [CAUSE_LEN-1:0] cause;
        logic [PRIV_LEN-1:0]  priv;
        // block type closed by each port, STD when it closes none
        itype_e               t0;
        itype_e               t1;
    } row_t;

    typedef struct packed {
        itype_e                 itype;
        logic [IRETIRE_LEN-1:0] iretire;
        logic                   ilast;
        logic [XLEN-1:0]        iaddr;
        logic [CAUSE_LEN-1:0]   cause;
        logic [XLEN-1:0]        tval;
        logic [PRIV_LEN-1:0]    priv;
    } block_t;

    logic                   clk_i;
    logic                   rst_ni;
    commit_instr_t          commit_instr [NRET-1:0];
    logic                   exception_valid_i;
    logic [CAUSE_LEN-1:0]   exception_cause_i;
    logic [XLEN-1:0]        exception_tval_i;
    logic                   interrupt_i;
    logic [PRIV_LEN-1:0]    priv_lvl_i;
    logic                   valid_o;
    logic [IRETIRE_LEN-1:0] iretire_o;
    logic                   ilastsize_o;
    itype_e                 itype_o;
    logic [CAUSE_LEN-1:0]   cause_o;
    logic [XLEN-1:0]        tval_o;
    logic [PRIV_LEN-1:0]    priv_o;
    logic [XLEN-1:0]        iaddr_o;

    row_t            rows     [NROWS];
    logic [XLEN-1:0] pc_tab   [NROWS][NRET];
    logic            comp_tab [NROWS][NRET];
    logic [XLEN-1:0] tval_tab [NROWS];
    block_t          exp_q    [$];
    int              n_exp;
    int              n_seen;

    multiple_retirement #(
        .NRET      (NRET),
        .FIFO_DEPTH(8)
    ) multiple_retirement_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .commit_instr_i   (commit_instr),
        .exception_valid_i(exception_valid_i),
        .exception_cause_i(exception_cause_i),
        .exception_tval_i (exception_tval_i),
        .interrupt_i      (interrupt_i),
        .priv_lvl_i       (priv_lvl_i),
        .valid_o          (valid_o),
        .iretire_o        (iretire_o),
        .ilastsize_o      (ilastsize_o),
        .itype_o          (itype_o),
        .cause_o          (cause_o),
        .tval_o           (tval_o),
        .priv_o           (priv_o),
        .iaddr_o          (iaddr_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic compare_field(input string name, input logic [XLEN-1:0] got,
                                 input logic [XLEN-1:0] exp);
        assert (got == exp) else report_error($sformatf(
            "CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp));
    endtask

    function automatic op_e op_of(input int r, input int p);
        return (p == 0) ? rows[r].op0 : rows[r].op1;
    endfunction

    function automatic itype_e type_of(input int r, input int p);
        return (p == 0) ? rows[r].t0 : rows[r].t1;
    endfunction

    task automatic fill_table();
        rows[0]  = '{2'b00, OP_OTHER,  OP_OTHER,  2'b00, 1'b0, 1'b0, 5'd0, 2'd3,
                     ITYPE_STD, ITYPE_STD};
        rows[1]  = '{2'b11, OP_OTHER,  OP_OTHER,  2'b00, 1'b0, 1'b0, 5'd0, 2'd3,
                     ITYPE_STD, ITYPE_STD};
        rows[2]  = '{2'b11, OP_OTHER,  OP_BRANCH, 2'b10, 1'b0, 1'b0, 5'd0, 2'd3,
                     ITYPE_STD, ITYPE_BR_T};
        rows[3]  = '{2'b11, OP_ERET,   OP_BRANCH, 2'b00, 1'b0, 1'b0, 5'd0, 2'd3,
                     ITYPE_ERET, ITYPE_BR_NT};
        rows[4]  = '{2'b11, OP_OTHER,  OP_OTHER,  2'b00, 1'b0, 1'b0, 5'd0, 2'd3,
                     ITYPE_STD, ITYPE_STD};
        // port 1 of the trapping group must vanish
        rows[5]  = '{2'b11, OP_OTHER,  OP_OTHER,  2'b00, 1'b1, 1'b0, 5'd2, 2'd3,
                     ITYPE_EXC, ITYPE_STD};
        rows[6]  = '{2'b11, OP_OTHER,  OP_BRANCH, 2'b10, 1'b0, 1'b0, 5'd0, 2'd3,
                     ITYPE_STD, ITYPE_BR_T};
        rows[7]  = '{2'b01, OP_OTHER,  OP_OTHER,  2'b00, 1'b0, 1'b1, 5'd7, 2'd3,
                     ITYPE_INT, ITYPE_STD};
        rows[8]  = '{2'b01, OP_OTHER,  OP_OTHER,  2'b00, 1'b0, 1'b0, 5'd0, 2'd0,
                     ITYPE_STD, ITYPE_STD};
        rows[9]  = '{2'b01, OP_BRANCH, OP_OTHER,  2'b01, 1'b0, 1'b0, 5'd0, 2'd1,
                     ITYPE_BR_T, ITYPE_STD};
        rows[10] = '{2'b00, OP_OTHER,  OP_OTHER,  2'b00, 1'b0, 1'b0, 5'd0, 2'd1,
                     ITYPE_STD, ITYPE_STD};
    endtask

    // random pc and size per port, expected blocks from the block rule
    task automatic build_expected();
        logic [IRETIRE_LEN-1:0] cnt;
        logic [XLEN-1:0]        start;
        logic                   open;
        logic                   last;
        logic                   skip;
        itype_e                 t;
        block_t                 b;
        cnt = '0;
        start = '0;
        open = 1'b0;
        last = 1'b0;
        for (int r = 0; r < NROWS; r++) begin
            tval_tab[r] = $urandom;
            skip = 1'b0;
            for (int p = 0; p < NRET; p++) begin
                pc_tab[r][p] = $urandom & 32'hffff_fffe;
                // branches alternate between 32 and 16 bit, ERET stays 32 bit
                if (op_of(r, p) == OP_OTHER) begin
                    comp_tab[r][p] = 1'($urandom % 2);
                end else begin
                    comp_tab[r][p] = (op_of(r, p) == OP_BRANCH) ? 1'(r % 2) : 1'b0;
                end
                t = type_of(r, p);
                b = '{t, cnt, 1'b0, start, 5'd0, 32'd0, rows[r].priv};
                if (rows[r].v[p] && !skip) begin
                    if (t == ITYPE_EXC || t == ITYPE_INT) begin
                        b.ilast = open && last;
                        b.iaddr = open ? start : pc_tab[r][p];
                        b.cause = rows[r].cause;
                        b.tval = tval_tab[r];
                        exp_q.push_back(b);
                        cnt = '0;
                        open = 1'b0;
                        skip = 1'b1;
                    end else begin
                        if (!open) begin
                            start = pc_tab[r][p];
                        end
                        cnt = cnt + (comp_tab[r][p] ? 8'd1 : 8'd2);
                        open = 1'b1;
                        last = !comp_tab[r][p];
                        if (t != ITYPE_STD) begin
                            b.iretire = cnt;
                            b.ilast = last;
                            b.iaddr = start;
                            exp_q.push_back(b);
                            cnt = '0;
                            open = 1'b0;
                        end
                    end
                end
            end
        end
    endtask

    task automatic drive_row(input int r);
        @(posedge clk_i);
        for (int p = 0; p < NRET; p++) begin
            commit_instr[p] <= '{valid: rows[r].v[p], pc: pc_tab[r][p], op: op_of(r, p),
                                 is_compressed: comp_tab[r][p], branch_taken: rows[r].tk[p]};
        end
        exception_valid_i <= rows[r].exc;
        interrupt_i       <= rows[r].intr;
        exception_cause_i <= rows[r].cause;
        exception_tval_i  <= tval_tab[r];
        priv_lvl_i        <= rows[r].priv;
        // let the serializer drain the group
        repeat (NRET) begin
            @(posedge clk_i);
            for (int p = 0; p < NRET; p++) begin
                commit_instr[p].valid <= 1'b0;
            end
            exception_valid_i <= 1'b0;
            interrupt_i       <= 1'b0;
        end
    endtask

    task automatic check_block();
        block_t e;
        assert (exp_q.size() > 0) else report_error("trace block seen with none expected");
        e = exp_q.pop_front();
        compare_field("itype", XLEN'(itype_o), XLEN'(e.itype));
        compare_field("iretire", XLEN'(iretire_o), XLEN'(e.iretire));
        compare_field("ilastsize", XLEN'(ilastsize_o), XLEN'(e.ilast));
        compare_field("iaddr", iaddr_o, e.iaddr);
        compare_field("priv", XLEN'(priv_o), XLEN'(e.priv));
        if (e.itype == ITYPE_EXC || e.itype == ITYPE_INT) begin
            compare_field("cause", XLEN'(cause_o), XLEN'(e.cause));
            compare_field("tval", tval_o, e.tval);
        end
        n_seen = n_seen + 1;
    endtask

    // outputs settle between rising edges
    always @(negedge clk_i) begin
        if (rst_ni && valid_o) begin
            check_block();
        end
    end

    task automatic wait_blocks();
        int cycles;
        cycles = 0;
        while (n_seen < n_exp && cycles < TIMEOUT) begin
            @(posedge clk_i);
            cycles = cycles + 1;
        end
        assert (n_seen == n_exp) else report_error("timeout waiting for trace blocks");
    endtask

    initial begin
        rst_ni = 1'b0;
        for (int p = 0; p < NRET; p++) begin
            commit_instr[p] = '0;
        end
        exception_valid_i = 1'b0;
        exception_cause_i = '0;
        exception_tval_i = '0;
        interrupt_i = 1'b0;
        priv_lvl_i = '0;
        n_seen = 0;
        void'($urandom(39));
        fill_table();
        build_expected();
        n_exp = exp_q.size();
        repeat (10) @(posedge clk_i);
        rst_ni <= 1'b1;
        for (int r = 0; r < NROWS; r++) begin
            drive_row(r);
        end
        wait_blocks();
        // stray blocks after the last one are caught by the monitor
        repeat (20) @(posedge clk_i);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
hdl/mure_pkg.sv
hdl/uop_if.sv
hdl/itype_detector.sv
hdl/uop_fifo.sv
hdl/retire_serializer.sv
hdl/block_builder.sv
hdl/multiple_retirement.sv
test/multiple_retirement_sva.sv
test/multiple_retirement_tb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module multiple_retirement_tb -o sim_tb \
    && ./obj_dir/sim_tb \
    || { echo "simulation did not pass"; exit 1; }
